/* verilog/coreDefs.sv */
// Core definitions shared by the single-cycle RV32I datapath and its control
package coreDefs;

    localparam int xlen        = 32;
    localparam int regAdrWidth = 5;
    localparam int byteLanes   = 4;

    localparam logic [xlen-1:0] resetVector = '0;

    // Major opcodes that the core executes
    typedef enum logic [6:0] {
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluSltu
    } aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSrcT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
    } branchCondT;

    typedef enum logic [1:0] {pcPlus4Src, pcBranch, pcJal, pcJalr} pcSrcT;

    typedef enum logic [0:0] {computeAlu, computePassthrough} computeSrcT;

    typedef enum logic [1:0] {passPcPlus4, passPcPlusImm, passImm} passthroughSrcT;

    typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} accessSizeT;

    // Instruction formats, all sharing the one 32-bit word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcodeT     opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcodeT      opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            opcodeT     opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            opcodeT     opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            opcodeT      opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            opcodeT     opcode;
        } jType;
    } instrWordT;

    typedef struct packed {
        logic           regWrite;
        immSrcT         immSrc;
        logic           aluSrcImm;
        aluOpT          aluOp;
        branchCondT     branchCond;
        logic           jump;
        logic           jumpReg;
        computeSrcT     computeSrc;
        passthroughSrcT passthroughSrc;
        logic           memEn;
        logic           memWriteEn;
        accessSizeT     memSize;
        logic           loadUnsigned;
        logic           resultFromMem;
    } controlT;

    typedef struct packed {
        logic                 en;
        logic                 writeEn;
        logic [byteLanes-1:0] byteEn;
        logic [xlen-1:0]      adr;
        logic [xlen-1:0]      writeData;
    } memRequestT;

endpackage

/* verilog/fetchUnit.sv */
// Program counter with next-PC selection for branches, jal and jalr
`timescale 1ns/1ps

module fetchUnit (
    input  logic                      clk,
    input  logic                      reset,
    input  coreDefs::controlT         control,
    input  logic                      branchTaken,
    input  logic [coreDefs::xlen-1:0] imm,
    input  logic [coreDefs::xlen-1:0] aluResult,
    output logic [coreDefs::xlen-1:0] pc,
    output logic [coreDefs::xlen-1:0] pcPlus4
);

    coreDefs::pcSrcT           pcSrc;
    logic [coreDefs::xlen-1:0] pcNext, pcPlusImm;

    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;

    always_comb begin
        if (control.jumpReg)      pcSrc = coreDefs::pcJalr;
        else if (control.jump)    pcSrc = coreDefs::pcJal;
        else if (branchTaken)     pcSrc = coreDefs::pcBranch;
        else                      pcSrc = coreDefs::pcPlus4Src;
    end

    always_comb begin
        case (pcSrc)
            // jalr target has its low bit cleared
            coreDefs::pcJalr:   pcNext = {aluResult[coreDefs::xlen-1:1], 1'b0};
            coreDefs::pcJal,
            coreDefs::pcBranch: pcNext = pcPlusImm;
            default:            pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= coreDefs::resetVector;
        else       pc <= pcNext;
    end

endmodule

/* verilog/controlDecoder.sv */
// Instruction decoder producing the control word from opcode and function fields
`timescale 1ns/1ps

module controlDecoder (
    input  coreDefs::instrWordT instr,
    output coreDefs::controlT   control
);

    logic [2:0]      funct3;
    logic            funct7Alt;
    coreDefs::aluOpT arithOp;

    assign funct3    = instr.rType.funct3;
    assign funct7Alt = instr.rType.funct7[5];

    // Arithmetic op shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (funct7Alt && instr.rType.opcode == coreDefs::opReg)
                               ? coreDefs::aluSub : coreDefs::aluAdd;
            3'b001:  arithOp = coreDefs::aluSll;
            3'b010:  arithOp = coreDefs::aluSlt;
            3'b011:  arithOp = coreDefs::aluSltu;
            3'b100:  arithOp = coreDefs::aluXor;
            3'b101:  arithOp = funct7Alt ? coreDefs::aluSra : coreDefs::aluSrl;
            3'b110:  arithOp = coreDefs::aluOr;
            default: arithOp = coreDefs::aluAnd;
        endcase
    end

    always_comb begin
        // Unknown opcodes fall through as a no-op
        control = '0;
        case (instr.rType.opcode)
            coreDefs::opImm: begin
                control.regWrite  = 1'b1;
                control.aluSrcImm = 1'b1;
                control.aluOp     = arithOp;
            end
            coreDefs::opReg: begin
                control.regWrite = 1'b1;
                control.aluOp    = arithOp;
            end
            coreDefs::opLui, coreDefs::opAuipc: begin
                control.regWrite       = 1'b1;
                control.immSrc         = coreDefs::immU;
                control.computeSrc     = coreDefs::computePassthrough;
                control.passthroughSrc = (instr.rType.opcode == coreDefs::opLui)
                                         ? coreDefs::passImm : coreDefs::passPcPlusImm;
            end
            coreDefs::opJal, coreDefs::opJalr: begin
                control.regWrite       = 1'b1;
                control.jump           = 1'b1;
                control.jumpReg        = instr.rType.opcode == coreDefs::opJalr;
                control.aluSrcImm      = 1'b1;
                control.immSrc         = control.jumpReg ? coreDefs::immI : coreDefs::immJ;
                control.computeSrc     = coreDefs::computePassthrough;
                control.passthroughSrc = coreDefs::passPcPlus4;
            end
            coreDefs::opBranch: begin
                control.immSrc = coreDefs::immB;
                control.aluOp  = coreDefs::aluSub;
                case (funct3)
                    3'b000:  control.branchCond = coreDefs::brEq;
                    3'b001:  control.branchCond = coreDefs::brNe;
                    3'b100:  control.branchCond = coreDefs::brLt;
                    3'b101:  control.branchCond = coreDefs::brGe;
                    3'b110:  control.branchCond = coreDefs::brLtu;
                    3'b111:  control.branchCond = coreDefs::brGeu;
                    default: control.branchCond = coreDefs::brNone;
                endcase
            end
            coreDefs::opLoad, coreDefs::opStore: begin
                control.aluSrcImm  = 1'b1;
                control.memEn      = 1'b1;
                control.memSize    = coreDefs::accessSizeT'(funct3[1:0]);
                control.memWriteEn = instr.rType.opcode == coreDefs::opStore;
                control.immSrc     = control.memWriteEn ? coreDefs::immS : coreDefs::immI;
                // Loads write back, stores do not
                control.regWrite      = ~control.memWriteEn;
                control.resultFromMem = ~control.memWriteEn;
                control.loadUnsigned  = funct3[2];
            end
            default: ;
        endcase
    end

endmodule

/* verilog/registerFile.sv */
// Integer register file, two combinational reads and one write, x0 held at zero
`timescale 1ns/1ps

module registerFile (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             writeEn,
    input  logic [coreDefs::regAdrWidth-1:0] rs1Adr,
    input  logic [coreDefs::regAdrWidth-1:0] rs2Adr,
    input  logic [coreDefs::regAdrWidth-1:0] rdAdr,
    input  logic [coreDefs::xlen-1:0]        rdData,
    output logic [coreDefs::xlen-1:0]        rs1,
    output logic [coreDefs::xlen-1:0]        rs2
);

    logic [coreDefs::xlen-1:0] regs [2**coreDefs::regAdrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**coreDefs::regAdrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAdr != '0) begin
            // x0 is never written
            regs[rdAdr] <= rdData;
        end
    end

    assign rs1 = regs[rs1Adr];
    assign rs2 = regs[rs2Adr];

endmodule

/* verilog/immediateExtender.sv */
// Immediate builder, sign-extends the I, S, B, U or J field of the instruction
`timescale 1ns/1ps

module immediateExtender (
    input  coreDefs::instrWordT       instr,
    input  coreDefs::immSrcT          immSrc,
    output logic [coreDefs::xlen-1:0] imm
);

    always_comb begin
        case (immSrc)
            coreDefs::immI: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            coreDefs::immS: imm = {{20{instr.sType.immHi[6]}},
                                   instr.sType.immHi, instr.sType.immLo};
            // Branch and jump offsets are in halfwords
            coreDefs::immB: imm = {{20{instr.bType.imm12}}, instr.bType.imm11,
                                   instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            coreDefs::immU: imm = {instr.uType.imm, 12'b0};
            coreDefs::immJ: imm = {{12{instr.jType.imm20}}, instr.jType.imm19to12,
                                   instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            default:        imm = '0;
        endcase
    end

endmodule

/* verilog/executeUnit.sv */
// Execute stage with ALU, branch condition and compute result select
`timescale 1ns/1ps

module executeUnit (
    input  coreDefs::controlT         control,
    input  logic [coreDefs::xlen-1:0] rs1,
    input  logic [coreDefs::xlen-1:0] rs2,
    input  logic [coreDefs::xlen-1:0] imm,
    input  logic [coreDefs::xlen-1:0] pc,
    input  logic [coreDefs::xlen-1:0] pcPlus4,
    output logic [coreDefs::xlen-1:0] aluResult,
    output logic [coreDefs::xlen-1:0] computeResult,
    output logic                      branchTaken
);

    localparam int msb = coreDefs::xlen - 1;

    logic [coreDefs::xlen-1:0]         operandB, difference, passthrough;
    logic [$clog2(coreDefs::xlen)-1:0] shamt;
    logic                              carry, zero, negative, overflow, lessSigned;

    assign operandB = control.aluSrcImm ? imm : rs2;
    assign shamt    = operandB[$clog2(coreDefs::xlen)-1:0];

    // One subtractor feeds sub, the compares and the branch flags
    assign {carry, difference} = {1'b0, rs1} + {1'b0, ~operandB} + 1'b1;
    assign zero       = difference == '0;
    assign negative   = difference[msb];
    assign overflow   = (rs1[msb] != operandB[msb]) && (difference[msb] != rs1[msb]);
    assign lessSigned = negative ^ overflow;

    always_comb begin
        case (control.aluOp)
            coreDefs::aluSub:  aluResult = difference;
            coreDefs::aluAnd:  aluResult = rs1 & operandB;
            coreDefs::aluOr:   aluResult = rs1 | operandB;
            coreDefs::aluXor:  aluResult = rs1 ^ operandB;
            coreDefs::aluSll:  aluResult = rs1 << shamt;
            coreDefs::aluSrl:  aluResult = rs1 >> shamt;
            coreDefs::aluSra:  aluResult = $signed(rs1) >>> shamt;
            coreDefs::aluSlt:  aluResult = {{msb{1'b0}}, lessSigned};
            // No carry out means rs1 is below operand B
            coreDefs::aluSltu: aluResult = {{msb{1'b0}}, ~carry};
            default:           aluResult = rs1 + operandB;
        endcase
    end

    always_comb begin
        case (control.branchCond)
            coreDefs::brEq:  branchTaken = zero;
            coreDefs::brNe:  branchTaken = ~zero;
            coreDefs::brLt:  branchTaken = lessSigned;
            coreDefs::brGe:  branchTaken = ~lessSigned;
            coreDefs::brLtu: branchTaken = ~carry;
            coreDefs::brGeu: branchTaken = carry;
            default:         branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (control.passthroughSrc)
            coreDefs::passPcPlusImm: passthrough = pc + imm;
            coreDefs::passImm:       passthrough = imm;
            default:                 passthrough = pcPlus4;
        endcase
    end

    assign computeResult = (control.computeSrc == coreDefs::computeAlu) ? aluResult : passthrough;

endmodule

/* verilog/loadStoreUnit.sv */
// Memory request forming and load lane extraction with sign or zero extension
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic                      reset,
    input  coreDefs::controlT         control,
    input  logic [coreDefs::xlen-1:0] computeResult,
    input  logic [coreDefs::xlen-1:0] rs2,
    input  logic [coreDefs::xlen-1:0] memReadData,
    output coreDefs::memRequestT      memRequest,
    output logic [coreDefs::xlen-1:0] rdData
);

    logic [$clog2(coreDefs::byteLanes)-1:0] byteOffset;
    logic [coreDefs::byteLanes-1:0]         byteEn;
    logic [coreDefs::xlen-1:0]              laneData, loadValue;
    logic                                   signBit;

    assign byteOffset = computeResult[$clog2(coreDefs::byteLanes)-1:0];

    always_comb begin
        case (control.memSize)
            coreDefs::sizeByte: byteEn = 4'b0001 << byteOffset;
            coreDefs::sizeHalf: byteEn = 4'b0011 << byteOffset;
            default:            byteEn = 4'b1111;
        endcase
    end

    // Store data moves up into the addressed lane
    assign memRequest = '{
        en:        control.memEn & ~reset,
        writeEn:   control.memWriteEn & ~reset,
        byteEn:    byteEn,
        adr:       computeResult,
        writeData: rs2 << {byteOffset, 3'b000}
    };

    // Loaded lane brought down to bit 0
    assign laneData = memReadData >> {byteOffset, 3'b000};

    always_comb begin
        case (control.memSize)
            coreDefs::sizeByte: begin
                signBit   = laneData[7] & ~control.loadUnsigned;
                loadValue = {{24{signBit}}, laneData[7:0]};
            end
            coreDefs::sizeHalf: begin
                signBit   = laneData[15] & ~control.loadUnsigned;
                loadValue = {{16{signBit}}, laneData[15:0]};
            end
            default: begin
                signBit   = 1'b0;
                loadValue = memReadData;
            end
        endcase
    end

    assign rdData = control.resultFromMem ? loadValue : computeResult;

endmodule

/* verilog/computeCore.sv */
// Single-cycle RV32I core top level, joining fetch, decode, execute and memory access
`timescale 1ns/1ps

module computeCore (
    input  logic                      clk,
    input  logic                      reset,
    output logic [coreDefs::xlen-1:0] pc,
    input  coreDefs::instrWordT       instr,
    output coreDefs::memRequestT      memRequest,
    input  logic [coreDefs::xlen-1:0] memReadData
);

    coreDefs::controlT         control;
    logic                      branchTaken;
    logic [coreDefs::xlen-1:0] pcPlus4, imm, rs1Value, rs2Value;
    logic [coreDefs::xlen-1:0] aluResult, computeResult, rdData;

    fetchUnit fetch (
        .clk, .reset, .control, .branchTaken, .imm, .aluResult,
        .pc, .pcPlus4
    );

    controlDecoder decoder (.instr, .control);

    // Register addresses sit at the same bits in every format
    registerFile regFile (
        .clk, .reset,
        .writeEn (control.regWrite),
        .rs1Adr  (instr.rType.rs1),
        .rs2Adr  (instr.rType.rs2),
        .rdAdr   (instr.rType.rd),
        .rdData  (rdData),
        .rs1     (rs1Value),
        .rs2     (rs2Value)
    );

    immediateExtender immExt (.instr, .immSrc(control.immSrc), .imm);

    executeUnit execute (
        .control, .rs1(rs1Value), .rs2(rs2Value), .imm, .pc, .pcPlus4,
        .aluResult, .computeResult, .branchTaken
    );

    loadStoreUnit loadStore (
        .reset, .control, .computeResult, .rs2(rs2Value), .memReadData,
        .memRequest, .rdData
    );

endmodule

/* verif/tbRefModel.svh */
// Reference RV32I model with its own registers and PC, plus the Fibonacci LFSR random source
`ifndef tbRefModelSvh
`define tbRefModelSvh

logic [31:0] lfsrState;
logic [31:0] modelRegs [32];
logic [31:0] modelPc;

// Taps 32, 22, 2 and 1
function automatic logic lfsrStep();
    logic feedback;
    feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    return feedback;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsrStep()};
    end
    return value;
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Executes the word at modelPc and returns the memory request it expects
function automatic coreDefs::memRequestT stepModel(input logic [31:0] w);
    coreDefs::memRequestT req;
    logic [31:0] rs1, rs2, immI, immS, immB, immJ, adr, result, nextPc, lane;
    logic [1:0]  offset;
    logic [3:0]  sizeEn;
    logic        writes, taken;
    rs1    = modelRegs[w[19:15]];
    rs2    = modelRegs[w[24:20]];
    immI   = {{20{w[31]}}, w[31:20]};
    immS   = {{20{w[31]}}, w[31:25], w[11:7]};
    immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    adr    = rs1 + ((w[6:0] == coreDefs::opStore) ? immS : immI);
    offset = adr[1:0];
    req    = '0;
    result = '0;
    writes = 1'b1;
    taken  = 1'b0;
    nextPc = modelPc + 32'd4;
    case (w[13:12])
        2'b00:   sizeEn = 4'b0001 << offset;
        2'b01:   sizeEn = 4'b0011 << offset;
        default: sizeEn = 4'b1111;
    endcase
    case (w[6:0])
        coreDefs::opImm:   result = aluRef(w[14:12], w[14:12] == 3'b101 && w[30], rs1, immI);
        coreDefs::opReg:   result = aluRef(w[14:12], w[30], rs1, rs2);
        coreDefs::opLui:   result = {w[31:12], 12'b0};
        coreDefs::opAuipc: result = modelPc + {w[31:12], 12'b0};
        coreDefs::opJal: begin
            result = modelPc + 32'd4;
            nextPc = modelPc + immJ;
        end
        coreDefs::opJalr: begin
            result = modelPc + 32'd4;
            nextPc = (rs1 + immI) & ~32'd1;
        end
        coreDefs::opBranch: begin
            writes = 1'b0;
            case (w[14:12])
                3'b000:  taken = rs1 == rs2;
                3'b001:  taken = rs1 != rs2;
                3'b100:  taken = $signed(rs1) < $signed(rs2);
                3'b101:  taken = $signed(rs1) >= $signed(rs2);
                3'b110:  taken = rs1 < rs2;
                3'b111:  taken = rs1 >= rs2;
                default: taken = 1'b0;
            endcase
            if (taken) nextPc = modelPc + immB;
        end
        coreDefs::opLoad: begin
            req.en     = 1'b1;
            req.adr    = adr;
            req.byteEn = sizeEn;
            lane       = dmem[adr[9:2]] >> {offset, 3'b000};
            case (w[14:12])
                3'b000:  result = {{24{lane[7]}}, lane[7:0]};
                3'b001:  result = {{16{lane[15]}}, lane[15:0]};
                3'b100:  result = {24'b0, lane[7:0]};
                3'b101:  result = {16'b0, lane[15:0]};
                default: result = lane;
            endcase
        end
        coreDefs::opStore: begin
            writes = 1'b0;
            req    = '{en: 1'b1, writeEn: 1'b1, byteEn: sizeEn, adr: adr,
                       writeData: rs2 << {offset, 3'b000}};
        end
        default: writes = 1'b0;
    endcase
    // x0 stays zero
    if (writes && w[11:7] != 5'd0) modelRegs[w[11:7]] = result;
    modelPc = nextPc;
    return req;
endfunction

`endif

/* verif/tbComputeCore.sv */
// Testbench for the single-cycle RV32I core checking a random program against a reference model
`timescale 1ns/1ps

module tbComputeCore;

    localparam int clkPeriod      = 100;
    localparam int stimDelay      = 1;
    localparam int checkLead      = 10;
    localparam int resetCycles    = 16;
    localparam int pcKnownTimeout = 4;
    localparam int runCycles      = 3000;
    localparam int memWords       = 256;

    logic                      clk = 1'b0;
    logic                      reset;
    logic [coreDefs::xlen-1:0] pc;
    coreDefs::instrWordT       instr;
    coreDefs::memRequestT      memRequest;
    logic [coreDefs::xlen-1:0] memReadData;

    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    int          errors;
    int          timeouts;
    int          checks;

    `include "tbRefModel.svh"

    always #(clkPeriod / 2) clk = ~clk;

    computeCore i_dut (.clk, .reset, .pc, .instr, .memRequest, .memReadData);

    always @(posedge clk) begin
        #stimDelay;
        instr = imem[pc[9:2]];
    end

    // Read data answers the request in the same cycle
    assign memReadData = dmem[memRequest.adr[9:2]];

    always @(posedge clk) begin
        if (memRequest.en && memRequest.writeEn) begin
            for (int b = 0; b < 4; b++) begin
                if (memRequest.byteEn[b]) begin
                    dmem[memRequest.adr[9:2]][8*b +: 8] <= memRequest.writeData[8*b +: 8];
                end
            end
        end
    end

    // Control flow only moves forward and the last word jumps back to the start
    function automatic int forwardTarget(input int idx);
        int target;
        target = idx + 1 + int'(randBits(4));
        return (target > memWords - 1) ? memWords - 1 : target;
    endfunction

    function automatic logic [31:0] randomInstr(input int idx);
        logic [3:0]  sel;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [19:0] upper;
        logic        alt;
        logic [31:0] off;
        sel   = 4'(randBits(4));
        rd    = 5'(randBits(5));
        rs1   = 5'(randBits(5));
        rs2   = 5'(randBits(5));
        f3    = 3'(randBits(3));
        imm   = 12'(randBits(12));
        upper = 20'(randBits(20));
        alt   = 1'(randBits(1));
        case (sel)
            4'd0, 4'd1, 4'd2: begin
                // Shift amounts keep funct7 clear except bit 30 for srai
                if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
                if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
                return {imm, rs1, f3, rd, coreDefs::opImm};
            end
            4'd3, 4'd4: return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                                rs2, rs1, f3, rd, coreDefs::opReg};
            4'd5: return {upper, rd, coreDefs::opLui};
            4'd6: return {upper, rd, coreDefs::opAuipc};
            4'd7: begin
                off = (forwardTarget(idx) - idx) * 4;
                return {off[20], off[10:1], off[11], off[19:12], rd, coreDefs::opJal};
            end
            4'd8: begin
                off = forwardTarget(idx) * 4;
                return {off[11:0], 5'd0, 3'b000, rd, coreDefs::opJalr};
            end
            4'd9, 4'd10: begin
                off = (forwardTarget(idx) - idx) * 4;
                if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]};
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], coreDefs::opBranch};
            end
            4'd11, 4'd12, 4'd13, 4'd14: begin
                // Absolute address on x0, aligned to the access size
                if (f3[1]) f3 = 3'b010;
                off = randBits(10);
                if (f3[1:0] == 2'b01) off[0] = 1'b0;
                if (f3[1:0] == 2'b10) off[1:0] = 2'b00;
                if (sel > 4'd12) begin
                    return {off[11:5], rs2, 5'd0, 1'b0, f3[1:0], off[4:0], coreDefs::opStore};
                end
                return {off[11:0], 5'd0, f3, rd, coreDefs::opLoad};
            end
            default: return {imm, rs1, f3, rd, alt ? 7'b1110011 : 7'b0001111};
        endcase
    endfunction

    task automatic checkResetState();
        checks++;
        if (pc !== coreDefs::resetVector || memRequest.en !== 1'b0
                || memRequest.writeEn !== 1'b0) begin
            errors++;
            $display("MISMATCH at %0t: in reset pc=%h en=%b writeEn=%b", $time, pc,
                     memRequest.en, memRequest.writeEn);
        end
    endtask

    task automatic compareAndStep();
        coreDefs::memRequestT expected;
        logic [31:0]          laneMask;
        checks++;
        if (pc !== modelPc) begin
            errors++;
            $display("MISMATCH at %0t: pc %h, expected %h", $time, pc, modelPc);
        end
        expected = stepModel(imem[modelPc[9:2]]);
        for (int b = 0; b < 4; b++) laneMask[8*b +: 8] = {8{expected.byteEn[b]}};
        if (memRequest.en !== expected.en || memRequest.writeEn !== expected.writeEn) begin
            errors++;
            $display("MISMATCH at %0t: en/writeEn %b%b, expected %b%b", $time, memRequest.en,
                     memRequest.writeEn, expected.en, expected.writeEn);
        end
        if (expected.en && (memRequest.adr !== expected.adr
                || memRequest.byteEn !== expected.byteEn)) begin
            errors++;
            $display("MISMATCH at %0t: adr %h byteEn %b, expected %h %b", $time, memRequest.adr,
                     memRequest.byteEn, expected.adr, expected.byteEn);
        end
        if (expected.writeEn
                && (memRequest.writeData & laneMask) !== (expected.writeData & laneMask)) begin
            errors++;
            $display("MISMATCH at %0t: writeData %h, expected %h in lanes %b", $time,
                     memRequest.writeData, expected.writeData, expected.byteEn);
        end
    endtask

    task automatic finishRun();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        int          resetEdges;
        logic        pcKnown;
        logic [31:0] backOffset;
        reset     = 1'b1;
        instr     = '0;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        lfsrState = 32'd19;
        for (int i = 0; i < memWords; i++) dmem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
        for (int i = 0; i < memWords - 1; i++) imem[i] = randomInstr(i);
        backOffset = 32'(-(memWords - 1) * 4);
        imem[memWords-1] = {backOffset[20], backOffset[10:1], backOffset[11],
                            backOffset[19:12], 5'd1, coreDefs::opJal};
        // A store at resetVector whose request must stay off during reset
        imem[0] = {7'b0, 5'd0, 5'd0, 3'b001, 5'd6, coreDefs::opStore};
        for (int r = 0; r < 32; r++) modelRegs[r] = '0;
        modelPc = coreDefs::resetVector;

        pcKnown    = 1'b0;
        resetEdges = 0;
        while (!pcKnown && resetEdges < pcKnownTimeout) begin
            @(posedge clk);
            resetEdges++;
            #(clkPeriod - checkLead);
            pcKnown = !$isunknown(pc);
        end
        if (!pcKnown) begin
            timeouts++;
            $display("Timeout: pc still unknown after %0d cycles in reset", resetEdges);
        end else begin
            checkResetState();
            while (resetEdges < resetCycles) begin
                @(posedge clk);
                resetEdges++;
                #stimDelay;
                if (resetEdges == resetCycles) reset = 1'b0;
                #(clkPeriod - checkLead - stimDelay);
                if (reset) checkResetState();
            end
            // First instruction at resetVector retires at the next edge
            for (int n = 0; n < runCycles; n++) begin
                compareAndStep();
                @(posedge clk);
                #(clkPeriod - checkLead);
            end
        end
        finishRun();
    end

endmodule

/* project.f */
+incdir+verif
verilog/coreDefs.sv
verilog/fetchUnit.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/immediateExtender.sv
verilog/executeUnit.sv
verilog/loadStoreUnit.sv
verilog/computeCore.sv
verif/tbComputeCore.sv
